//--- common/echo_app_pkg.sv
`default_nettype none

package echo_app_pkg;

    localparam int DATA_W = 64;
    localparam int CONN_ID_W = 8;
    localparam int MAX_MSG_WORDS = 16;
    localparam int LEN_W = $clog2(MAX_MSG_WORDS + 1); // Holds 1..16.
    localparam int ADDR_W = 16;

    localparam int FIFO_DEPTH = 2 * MAX_MSG_WORDS; // Two full messages.
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // Inbound header word layout.
    localparam int HDR_LEN_LSB = 0;
    localparam int HDR_CONN_LSB = 8;

    localparam logic [3:0] FLIT_TX_REQ = 4'h1;
    localparam logic [3:0] FLIT_PTR_UPD = 4'h2;

    typedef enum logic [0:0] {
        BODY_VALUES = 1'b0,
        PTR_UPDATE  = 1'b1
    } buf_mux_sel_e;

    typedef union packed {
        struct packed {
            logic [3:0]                               flit_type;
            logic [CONN_ID_W-1:0]                     conn_id;
            logic [LEN_W-1:0]                         len;
            logic [DATA_W-4-CONN_ID_W-LEN_W-1:0]      rsvd;
        } tx_req;
        struct packed {
            logic [3:0]                               flit_type;
            logic [CONN_ID_W-1:0]                     conn_id;
            logic [ADDR_W-1:0]                        new_tail;
            logic [DATA_W-4-CONN_ID_W-ADDR_W-1:0]     rsvd;
        } ptr_upd;
    } noc_flit_u;

endpackage

`default_nettype wire

//--- common/echo_msg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface echo_msg_if;
    import echo_app_pkg::*;

    logic                   msg_val;
    logic                   msg_rdy;
    logic [CONN_ID_W-1:0]   conn_id;
    logic [LEN_W-1:0]       len;

    modport src   (output msg_val, output conn_id, output len, input msg_rdy);
    modport ctrl  (input msg_val, output msg_rdy);
    modport datap (input conn_id, input len);

endinterface

`default_nettype wire

//--- common/echo_wr_buf_if.sv
`timescale 1ns/1ps
`default_nettype none

interface echo_wr_buf_if;
    import echo_app_pkg::*;

    logic                   req_val;
    logic                   req_rdy;
    logic [ADDR_W-1:0]      req_addr;
    logic [LEN_W-1:0]       req_len;

    logic                   data_val;
    logic                   data_rdy;
    logic [DATA_W-1:0]      data;

    logic                   done;
    logic                   done_rdy;

    modport ctrl (
        output req_val, output data_val, output done_rdy,
        input  req_rdy, input  data_rdy, input  done
    );
    modport datap (
        output req_addr, output req_len, output data
    );
    modport mem (
        input  req_val, input  req_addr, input  req_len,
        input  data_val, input  data, input  done_rdy,
        output req_rdy, output data_rdy, output done
    );

endinterface

`default_nettype wire

//--- hdl/echo_app_rx_msg_if.sv
`timescale 1ns/1ps
`default_nettype none

module echo_app_rx_msg_if (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                in_val,
    output logic                                in_rdy,
    input  logic [echo_app_pkg::DATA_W-1:0]     in_data,

    output logic                                fifo_wr_en,
    output logic [echo_app_pkg::DATA_W-1:0]     fifo_wr_data,
    input  logic                                fifo_full,

    echo_msg_if.src                             msg
);
    import echo_app_pkg::*;

    typedef enum logic {
        HEADER  = 1'b0,
        PAYLOAD = 1'b1
    } state_e;

    state_e                 state_reg;
    logic [LEN_W-1:0]       words_left;
    logic [CONN_ID_W-1:0]   cur_conn;
    logic [LEN_W-1:0]       cur_len;
    logic                   desc_val;
    logic [CONN_ID_W-1:0]   desc_conn;
    logic [LEN_W-1:0]       desc_len;
    logic                   in_xfer;
    logic                   last_word;

    // A header waits until the pending descriptor is free or leaving now.
    assign in_rdy = (state_reg == HEADER) ? (!desc_val || msg.msg_rdy) : !fifo_full;
    assign in_xfer = in_val && in_rdy;
    assign last_word = (state_reg == PAYLOAD) && in_xfer && (words_left == LEN_W'(1));

    assign fifo_wr_en = (state_reg == PAYLOAD) && in_xfer;
    assign fifo_wr_data = in_data;

    assign msg.msg_val = desc_val;
    assign msg.conn_id = desc_conn;
    assign msg.len = desc_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= HEADER;
            words_left <= '0;
            desc_val <= 1'b0;
        end else begin
            if (state_reg == HEADER && in_xfer) begin
                words_left <= in_data[HDR_LEN_LSB +: LEN_W];
                state_reg <= PAYLOAD;
            end else if (fifo_wr_en) begin
                words_left <= words_left - 1'b1;
                if (last_word) begin
                    state_reg <= HEADER;
                end
            end

            if (last_word) begin
                desc_val <= 1'b1; // Whole payload is in the FIFO.
            end else if (msg.msg_rdy) begin
                desc_val <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_reg == HEADER && in_xfer) begin
            cur_conn <= in_data[HDR_CONN_LSB +: CONN_ID_W];
            cur_len <= in_data[HDR_LEN_LSB +: LEN_W];
        end
        if (last_word) begin
            desc_conn <= cur_conn;
            desc_len <= cur_len;
        end
    end

endmodule

`default_nettype wire

//--- hdl/echo_payload_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module echo_payload_fifo (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                wr_en,
    input  logic [echo_app_pkg::DATA_W-1:0]     wr_data,
    output logic                                full,

    input  logic                                rd_en,
    output logic [echo_app_pkg::DATA_W-1:0]     rd_data
);
    import echo_app_pkg::*;

    logic [DATA_W-1:0]      mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0]     wr_ptr;
    logic [FIFO_AW-1:0]     rd_ptr;
    logic [FIFO_AW:0]       count;

    assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign rd_data = mem[rd_ptr]; // Head word.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at the power-of-two depth.
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- echo_app_tx/echo_app_tx_msg_if_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module echo_app_tx_msg_if_ctrl (
    input  logic                        clk,
    input  logic                        rst,

    echo_msg_if.ctrl                    msg,

    output logic                        noc_out_val,
    input  logic                        noc_out_rdy,

    input  logic                        noc_in_val,
    output logic                        noc_in_rdy,

    echo_wr_buf_if.ctrl                 wr,

    output logic                        store_inputs,
    output logic                        decr_words_left,
    output echo_app_pkg::buf_mux_sel_e  buf_mux_sel,
    output logic                        store_notif,

    input  logic                        last_wr,

    output logic                        req_done
);
    import echo_app_pkg::*;

    typedef enum logic [2:0] {
        READY          = 3'd0,
        TX_MSG_REQ     = 3'd1,
        TX_MSG_NOTIF   = 3'd2,
        TX_WR_MEM_REQ  = 3'd3,
        PAYLOAD_COPY   = 3'd4,
        WAIT_WR_RESP   = 3'd5,
        ADJUST_TX_TAIL = 3'd6
    } state_e;

    state_e state_reg;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        msg.msg_rdy = 1'b0;

        noc_out_val = 1'b0;
        noc_in_rdy = 1'b0;

        store_inputs = 1'b0;
        decr_words_left = 1'b0;
        buf_mux_sel = BODY_VALUES;
        store_notif = 1'b0;

        wr.req_val = 1'b0;
        wr.data_val = 1'b0;
        wr.done_rdy = 1'b0;

        req_done = 1'b0;

        state_next = state_reg;
        case (state_reg)
            READY: begin
                msg.msg_rdy = 1'b1;
                if (msg.msg_val) begin
                    store_inputs = 1'b1; // Capture the accepted descriptor.
                    state_next = TX_MSG_REQ;
                end
            end
            TX_MSG_REQ: begin
                buf_mux_sel = BODY_VALUES;
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_next = TX_MSG_NOTIF;
                end
            end
            TX_MSG_NOTIF: begin
                store_notif = 1'b1;
                noc_in_rdy = 1'b1;
                if (noc_in_val) begin
                    state_next = TX_WR_MEM_REQ;
                end
            end
            TX_WR_MEM_REQ: begin
                wr.req_val = 1'b1;
                if (wr.req_rdy) begin
                    state_next = PAYLOAD_COPY;
                end
            end
            PAYLOAD_COPY: begin
                wr.data_val = 1'b1;
                if (wr.data_rdy) begin
                    decr_words_left = 1'b1;
                    if (last_wr) begin
                        state_next = WAIT_WR_RESP;
                    end
                end
            end
            WAIT_WR_RESP: begin
                wr.done_rdy = 1'b1;
                if (wr.done) begin
                    state_next = ADJUST_TX_TAIL;
                end
            end
            ADJUST_TX_TAIL: begin
                noc_out_val = 1'b1;
                buf_mux_sel = PTR_UPDATE;
                if (noc_out_rdy) begin
                    req_done = 1'b1;
                    state_next = READY;
                end
            end
            default: begin
                msg.msg_rdy = 'X;
                noc_out_val = 'X;
                noc_in_rdy = 'X;
                store_inputs = 'X;
                decr_words_left = 'X;
                store_notif = 'X;
                wr.req_val = 'X;
                wr.data_val = 'X;
                wr.done_rdy = 'X;
                req_done = 'X;

                state_next = READY; // Unused encoding recovers to idle.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- echo_app_tx/echo_app_tx_msg_if_datap.sv
`timescale 1ns/1ps
`default_nettype none

module echo_app_tx_msg_if_datap (
    input  logic                                clk,
    input  logic                                rst,

    echo_msg_if.datap                           msg,

    input  logic [echo_app_pkg::DATA_W-1:0]     noc_in_data,
    output echo_app_pkg::noc_flit_u             noc_out_data,

    echo_wr_buf_if.datap                        wr,

    input  logic [echo_app_pkg::DATA_W-1:0]     fifo_rd_data,

    input  logic                                store_inputs,
    input  logic                                decr_words_left,
    input  echo_app_pkg::buf_mux_sel_e          buf_mux_sel,
    input  logic                                store_notif,

    output logic                                last_wr
);
    import echo_app_pkg::*;

    logic [CONN_ID_W-1:0]   conn_id_reg;
    logic [LEN_W-1:0]       len_reg;
    logic [LEN_W-1:0]       words_left;
    logic [ADDR_W-1:0]      base_addr;
    logic [LEN_W-1:0]       words_written;

    always_ff @(posedge clk) begin
        if (rst) begin
            words_left <= '0;
        end else if (store_inputs) begin
            words_left <= msg.len;
        end else if (decr_words_left) begin
            words_left <= words_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_inputs) begin
            conn_id_reg <= msg.conn_id;
            len_reg <= msg.len;
        end
        if (store_notif) begin
            base_addr <= noc_in_data[ADDR_W-1:0]; // Base sits in the low bits.
        end
    end

    assign words_written = len_reg - words_left;
    assign last_wr = (words_left == LEN_W'(1));

    assign wr.req_addr = base_addr + ADDR_W'(words_written);
    assign wr.req_len = len_reg;
    assign wr.data = fifo_rd_data;

    always_comb begin
        noc_out_data = '0;
        if (buf_mux_sel == PTR_UPDATE) begin
            noc_out_data.ptr_upd.flit_type = FLIT_PTR_UPD;
            noc_out_data.ptr_upd.conn_id = conn_id_reg;
            noc_out_data.ptr_upd.new_tail = base_addr + ADDR_W'(len_reg);
        end else begin
            noc_out_data.tx_req.flit_type = FLIT_TX_REQ;
            noc_out_data.tx_req.conn_id = conn_id_reg;
            noc_out_data.tx_req.len = len_reg;
        end
    end

endmodule

`default_nettype wire

//--- hdl/echo_app_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module echo_app_tx_top (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                in_val,
    output logic                                in_rdy,
    input  logic [echo_app_pkg::DATA_W-1:0]     in_data,

    output logic                                noc_out_val,
    input  logic                                noc_out_rdy,
    output logic [echo_app_pkg::DATA_W-1:0]     noc_out_data,

    input  logic                                noc_in_val,
    output logic                                noc_in_rdy,
    input  logic [echo_app_pkg::DATA_W-1:0]     noc_in_data,

    output logic                                wr_req_val,
    input  logic                                wr_req_rdy,
    output logic [echo_app_pkg::ADDR_W-1:0]     wr_req_addr,
    output logic [echo_app_pkg::LEN_W-1:0]      wr_req_len,
    output logic                                wr_data_val,
    input  logic                                wr_data_rdy,
    output logic [echo_app_pkg::DATA_W-1:0]     wr_data,
    input  logic                                wr_done,
    output logic                                wr_done_rdy,

    output logic                                req_done
);
    import echo_app_pkg::*;

    logic               fifo_wr_en;
    logic [DATA_W-1:0]  fifo_wr_data;
    logic               fifo_full;
    logic               fifo_rd_en;
    logic [DATA_W-1:0]  fifo_rd_data;
    logic               store_inputs;
    logic               decr_words_left;
    logic               store_notif;
    logic               last_wr;
    buf_mux_sel_e       buf_mux_sel;
    noc_flit_u          noc_out_flit;

    echo_msg_if    msg_if ();
    echo_wr_buf_if wr_if ();

    assign fifo_rd_en = wr_if.data_val && wr_if.data_rdy; // Pop on each data transfer.
    assign noc_out_data = noc_out_flit;

    assign wr_req_val = wr_if.req_val;
    assign wr_req_addr = wr_if.req_addr;
    assign wr_req_len = wr_if.req_len;
    assign wr_data_val = wr_if.data_val;
    assign wr_data = wr_if.data;
    assign wr_done_rdy = wr_if.done_rdy;
    assign wr_if.req_rdy = wr_req_rdy;
    assign wr_if.data_rdy = wr_data_rdy;
    assign wr_if.done = wr_done;

    echo_app_rx_msg_if u_rx (
        .clk, .rst, .in_val, .in_rdy, .in_data,
        .fifo_wr_en, .fifo_wr_data, .fifo_full,
        .msg (msg_if.src)
    );

    echo_payload_fifo u_fifo (
        .clk, .rst,
        .wr_en (fifo_wr_en), .wr_data (fifo_wr_data), .full (fifo_full),
        .rd_en (fifo_rd_en), .rd_data (fifo_rd_data)
    );

    echo_app_tx_msg_if_ctrl u_ctrl (
        .clk, .rst, .msg (msg_if.ctrl),
        .noc_out_val, .noc_out_rdy, .noc_in_val, .noc_in_rdy,
        .wr (wr_if.ctrl),
        .store_inputs, .decr_words_left, .buf_mux_sel, .store_notif,
        .last_wr, .req_done
    );

    echo_app_tx_msg_if_datap u_datap (
        .clk, .rst, .msg (msg_if.datap),
        .noc_in_data, .noc_out_data (noc_out_flit),
        .wr (wr_if.datap), .fifo_rd_data,
        .store_inputs, .decr_words_left, .buf_mux_sel, .store_notif,
        .last_wr
    );

endmodule

`default_nettype wire

//--- tests/echo_app_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module echo_app_asserts (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        noc_out_val,
    input  logic                        noc_out_rdy,
    input  echo_app_pkg::buf_mux_sel_e  buf_mux_sel,
    input  logic                        req_val,
    input  logic                        req_rdy,
    input  logic                        data_val,
    input  logic                        data_rdy,
    input  logic                        done,
    input  logic                        done_rdy,
    input  logic                        last_wr,
    input  logic                        req_done
);
    int     fail_count = 0;
    logic   in_copy;

    // Open between an accepted write request and the last data word.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_copy <= 1'b0;
        end else if (req_val && req_rdy) begin
            in_copy <= 1'b1;
        end else if (data_val && data_rdy && last_wr) begin
            in_copy <= 1'b0;
        end
    end

    flit_held: assert property (@(posedge clk) disable iff (rst)
        noc_out_val && !noc_out_rdy |=> noc_out_val && $stable(buf_mux_sel))
        else begin fail_count++; $error("outbound flit dropped before ready"); end

    req_held: assert property (@(posedge clk) disable iff (rst)
        req_val && !req_rdy |=> req_val)
        else begin fail_count++; $error("write request dropped before ready"); end

    data_held: assert property (@(posedge clk) disable iff (rst)
        data_val && !data_rdy |=> data_val)
        else begin fail_count++; $error("write data dropped before ready"); end

    done_rdy_held: assert property (@(posedge clk) disable iff (rst)
        done_rdy && !done |=> done_rdy)
        else begin fail_count++; $error("done ready dropped before done"); end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        req_done |=> !req_done)
        else begin fail_count++; $error("req_done longer than one cycle"); end

    no_fifo_underflow: assert property (@(posedge clk) disable iff (rst)
        data_val |-> in_copy)
        else begin fail_count++; $error("FIFO read outside a payload copy"); end

endmodule

bind echo_app_tx_msg_if_ctrl echo_app_asserts u_ctrl_asserts (
    .clk, .rst, .noc_out_val, .noc_out_rdy, .buf_mux_sel,
    .req_val (wr.req_val), .req_rdy (wr.req_rdy),
    .data_val (wr.data_val), .data_rdy (wr.data_rdy),
    .done (wr.done), .done_rdy (wr.done_rdy),
    .last_wr, .req_done
);

`default_nettype wire

//--- tests/tb_echo_app.sv
`timescale 1ns/1ps
`default_nettype none

module tb_echo_app;
    import echo_app_pkg::*;

    localparam int NUM_MSGS = 40;
    localparam int CLK_PERIOD = 40;
    localparam int GAP_FROM = 20; // Earlier messages arrive back to back.

    logic                   clk;
    logic                   rst;
    logic                   in_val;
    logic                   in_rdy;
    logic [DATA_W-1:0]      in_data;
    logic                   noc_out_val;
    logic                   noc_out_rdy;
    logic [DATA_W-1:0]      noc_out_data;
    logic                   noc_in_val;
    logic                   noc_in_rdy;
    logic [DATA_W-1:0]      noc_in_data;
    logic                   wr_req_val;
    logic                   wr_req_rdy;
    logic [ADDR_W-1:0]      wr_req_addr;
    logic [LEN_W-1:0]       wr_req_len;
    logic                   wr_data_val;
    logic                   wr_data_rdy;
    logic [DATA_W-1:0]      wr_data;
    logic                   wr_done;
    logic                   wr_done_rdy;
    logic                   req_done;

    logic [15:0]            lfsr_state;
    logic [DATA_W-1:0]      in_words[$];
    bit                     in_gappy[$];
    logic [CONN_ID_W-1:0]   exp_conn[$];
    logic [LEN_W-1:0]       exp_len[$];
    logic [DATA_W-1:0]      exp_pay[$];
    logic [CONN_ID_W-1:0]   cur_conn;
    logic [LEN_W-1:0]       cur_len;
    logic [ADDR_W-1:0]      cur_base;
    bit                     msg_given;
    bit                     notif_pending;
    bit                     req_seen;
    bit                     done_pending;
    bit                     done_seen;
    bit                     in_acc;
    bit                     notif_acc;
    bit                     done_acc;
    int                     words_seen;
    int                     done_count;

    echo_app_tx_top u_dut (
        .clk, .rst, .in_val, .in_rdy, .in_data,
        .noc_out_val, .noc_out_rdy, .noc_out_data,
        .noc_in_val, .noc_in_rdy, .noc_in_data,
        .wr_req_val, .wr_req_rdy, .wr_req_addr, .wr_req_len,
        .wr_data_val, .wr_data_rdy, .wr_data, .wr_done, .wr_done_rdy,
        .req_done
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400; // Taps 16, 14, 13, 11.
        end
        return n;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic mismatch(input string what);
        $display("MISMATCH at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic build_messages();
        logic [LEN_W-1:0]       len;
        logic [CONN_ID_W-1:0]   conn;
        logic [DATA_W-1:0]      hdr;
        logic [DATA_W-1:0]      word;
        for (int m = 0; m < NUM_MSGS; m++) begin
            len = LEN_W'(rand_bits(4)) + 1'b1; // 1 to 16 words.
            conn = CONN_ID_W'(rand_bits(CONN_ID_W));
            hdr = '0;
            hdr[HDR_LEN_LSB +: LEN_W] = len;
            hdr[HDR_CONN_LSB +: CONN_ID_W] = conn;
            in_words.push_back(hdr);
            in_gappy.push_back(m >= GAP_FROM);
            exp_conn.push_back(conn);
            exp_len.push_back(len);
            for (int w = 0; w < int'(len); w++) begin
                word = rand_bits(DATA_W);
                in_words.push_back(word);
                in_gappy.push_back(m >= GAP_FROM);
                exp_pay.push_back(word);
            end
        end
    endtask

    task automatic check_flit(input noc_flit_u flit);
        if (flit.tx_req.flit_type == FLIT_TX_REQ) begin
            assert (exp_conn.size() > 0) else mismatch("request flit with no message pending");
            assert (flit.tx_req.conn_id == exp_conn[0] && flit.tx_req.len == exp_len[0])
                else mismatch($sformatf("request conn %0h len %0d, expected conn %0h len %0d",
                    flit.tx_req.conn_id, flit.tx_req.len, exp_conn[0], exp_len[0]));
            cur_conn = exp_conn.pop_front();
            cur_len = exp_len.pop_front();
            notif_pending = 1'b1;
            req_seen = 1'b0;
            done_seen = 1'b0;
        end else if (flit.ptr_upd.flit_type == FLIT_PTR_UPD) begin
            assert (done_seen) else mismatch("pointer update before write done");
            assert (flit.ptr_upd.conn_id == cur_conn
                    && flit.ptr_upd.new_tail == ADDR_W'(cur_base + ADDR_W'(cur_len)))
                else mismatch($sformatf("pointer update conn %0h tail %0h, expected %0h %0h",
                    flit.ptr_upd.conn_id, flit.ptr_upd.new_tail, cur_conn,
                    ADDR_W'(cur_base + ADDR_W'(cur_len))));
            done_seen = 1'b0;
            done_count++;
        end else begin
            mismatch($sformatf("unknown flit type %0h", flit.tx_req.flit_type));
        end
    endtask

    // Values seen here are the ones the next rising edge transfers.
    task automatic sample_transfers();
        noc_flit_u flit;
        flit = noc_out_data;
        in_acc = in_val && in_rdy;
        notif_acc = noc_in_val && noc_in_rdy;
        done_acc = wr_done && wr_done_rdy;
        if (notif_acc) begin
            cur_base = noc_in_data[ADDR_W-1:0];
            notif_pending = 1'b0;
        end
        if (done_acc) begin
            done_seen = 1'b1;
        end
        assert (req_done == (noc_out_val && noc_out_rdy
                && flit.ptr_upd.flit_type == FLIT_PTR_UPD))
            else mismatch("req_done does not match the pointer update transfer");
        if (noc_out_val && noc_out_rdy) begin
            check_flit(flit);
        end
        if (wr_req_val && wr_req_rdy) begin
            assert (!req_seen && wr_req_addr == cur_base && wr_req_len == cur_len)
                else mismatch($sformatf("write request addr %0h len %0d, expected %0h %0d",
                    wr_req_addr, wr_req_len, cur_base, cur_len));
            req_seen = 1'b1;
            words_seen = 0;
        end
        if (wr_data_val && wr_data_rdy) begin
            assert (req_seen && words_seen < int'(cur_len) && exp_pay.size() > 0)
                else mismatch("data word outside its write request");
            assert (wr_data == exp_pay[0])
                else mismatch($sformatf("data %0h, expected %0h", wr_data, exp_pay[0]));
            void'(exp_pay.pop_front());
            words_seen++;
            if (words_seen == int'(cur_len)) begin
                done_pending = 1'b1;
            end
        end
    endtask

    task automatic drive_inputs();
        if (in_acc) begin
            void'(in_words.pop_front());
            void'(in_gappy.pop_front());
        end
        if (!in_val || in_acc) begin
            in_val = 1'b0;
            if (in_words.size() > 0 && (!in_gappy[0] || rand_bits(1) == 1)) begin
                in_val = 1'b1;
                in_data = in_words[0];
                msg_given = 1'b1;
            end
        end
        noc_out_rdy = (rand_bits(2) != 0);
        wr_req_rdy = (rand_bits(2) != 0);
        wr_data_rdy = (rand_bits(2) != 0);
        if (notif_acc) begin
            noc_in_val = 1'b0;
        end else if (notif_pending && !noc_in_val && rand_bits(1) == 1) begin
            noc_in_val = 1'b1;
            noc_in_data = rand_bits(DATA_W); // Upper bits are noise.
        end
        if (done_acc) begin
            wr_done = 1'b0;
            done_pending = 1'b0;
        end else if (done_pending && !wr_done && rand_bits(1) == 1) begin
            wr_done = 1'b1;
        end
    endtask

    quiet_before_first_msg: assert property (@(posedge clk) disable iff (rst)
        !msg_given |-> !(noc_out_val || wr_req_val || wr_data_val || wr_done_rdy || req_done))
        else mismatch("output active before the first message");

    initial begin
        lfsr_state = 16'd7179;
        build_messages();
        rst = 1'b1;
        in_val = 1'b0;
        in_data = '0;
        noc_out_rdy = 1'b0;
        noc_in_val = 1'b0;
        noc_in_data = '0;
        wr_req_rdy = 1'b0;
        wr_data_rdy = 1'b0;
        wr_done = 1'b0;
        words_seen = 0;
        done_count = 0;
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
        while (done_count < NUM_MSGS) begin
            @(negedge clk);
            if (u_dut.u_ctrl.u_ctrl_asserts.fail_count != 0) begin
                $display("A protocol assertion in the tx controller failed");
                abort_run();
            end
            sample_transfers();
            @(posedge clk);
            #2;
            drive_inputs();
        end
        repeat (4) @(posedge clk);
        if (exp_conn.size() == 0 && exp_pay.size() == 0
                && u_dut.u_ctrl.u_ctrl_asserts.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Scoreboard not empty or a protocol assertion failed");
            abort_run();
        end
    end

    initial begin
        repeat (NUM_MSGS * 200 + 16) @(posedge clk);
        $display("Timeout: not all messages were echoed in time");
        abort_run();
    end

endmodule

`default_nettype wire

//--- filelist.f
common/echo_app_pkg.sv
common/echo_msg_if.sv
common/echo_wr_buf_if.sv
hdl/echo_app_rx_msg_if.sv
hdl/echo_payload_fifo.sv
echo_app_tx/echo_app_tx_msg_if_ctrl.sv
echo_app_tx/echo_app_tx_msg_if_datap.sv
hdl/echo_app_tx_top.sv
tests/echo_app_asserts.sv
tests/tb_echo_app.sv
